// ==== project.f ====
design/wb_pkg.sv
design/load_align.sv
design/exec_result_fmt.sv
design/wb_arbiter.sv
design/gpr_file.sv
design/wb_subsystem.sv
verification/wb_assert.sv
verification/tb_wb_subsystem.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f project.f --top-module tb_wb_subsystem -o sim_tb

output=$(./obj_dir/sim_tb 2>&1 || true)
echo "$output"

# the run passes only if the pass line was printed
echo "$output" | grep -q "TEST RESULT: PASS"

// ==== verification/tb_wb_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_wb_subsystem;
    import wb_pkg::*;

    localparam int reg_count = 32;
    localparam int addr_w = $clog2(reg_count);
    localparam int n_trans = 400; // items per path
    localparam int timeout_cycles = 2 * n_trans * 20 + 200;

    logic                clk;
    logic                rst_n;
    logic                ex_valid;
    logic                ex_ready;
    logic [addr_w-1:0]   ex_rd;
    logic [data_w-1:0]   ex_result;
    logic                ex_word;
    logic                mem_valid;
    logic                mem_ready;
    logic [addr_w-1:0]   mem_rd;
    logic [data_w-1:0]   mem_rdata;
    logic [offset_w-1:0] mem_offset;
    mem_size_e           mem_size;
    logic                mem_unsigned;
    logic [addr_w-1:0]   rd_addr;
    logic [data_w-1:0]   rd_data;
    logic                commit_valid;
    logic [addr_w-1:0]   commit_rd;
    logic [data_w-1:0]   commit_data;

    // expected results per path, in transfer order
    logic [addr_w-1:0] ex_rd_q[$];
    logic [data_w-1:0] ex_data_q[$];
    logic [addr_w-1:0] mem_rd_q[$];
    logic [data_w-1:0] mem_data_q[$];
    int                mem_cycle_q[$]; // cycle of each load transfer
    logic [data_w-1:0] model_regs [reg_count];
    int                commit_count;
    int                cycle_count;

    wb_subsystem #(.reg_count(reg_count)) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_valid     (ex_valid),
        .ex_ready     (ex_ready),
        .ex_rd        (ex_rd),
        .ex_result    (ex_result),
        .ex_word      (ex_word),
        .mem_valid    (mem_valid),
        .mem_ready    (mem_ready),
        .mem_rd       (mem_rd),
        .mem_rdata    (mem_rdata),
        .mem_offset   (mem_offset),
        .mem_size     (mem_size),
        .mem_unsigned (mem_unsigned),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic stop_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [63:0] actual,
                                 input logic [63:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected);
            stop_with_failure();
        end
    endtask

    // word ops keep bits 31:0 and copy bit 31 upward
    function automatic logic [63:0] formatted_exec_value(input logic [63:0] result,
                                                         input logic word);
        if (word) begin
            return {{32{result[31]}}, result[31:0]};
        end
        return result;
    endfunction

    // byte by byte, bytes past the doubleword end read as zero
    function automatic logic [63:0] aligned_load_value(input logic [63:0] rdata,
                                                       input logic [2:0] offset,
                                                       input logic [1:0] size,
                                                       input logic uns);
        logic [63:0] value;
        int          nbytes;
        int          pos;
        logic        sign;
        value = '0;
        nbytes = 1 << size;
        for (int i = 0; i < 8; i++) begin
            pos = int'(offset) + i;
            if (i < nbytes && pos < 8) begin
                value[8*i +: 8] = rdata[8*pos +: 8];
            end
        end
        if (!uns && nbytes < 8) begin
            sign = value[8*nbytes-1];
            for (int b = 8 * nbytes; b < 64; b++) begin
                value[b] = sign;
            end
        end
        return value;
    endfunction

    task automatic exec_traffic();
        int          sent;
        logic        fire;
        logic [31:0] r;
        sent = 0;
        while (sent < n_trans) begin
            @(negedge clk);
            fire = ex_valid & ex_ready; // transfer at the coming edge
            @(posedge clk);
            #1;
            if (fire) begin
                ex_rd_q.push_back(ex_rd);
                ex_data_q.push_back(formatted_exec_value(ex_result, ex_word));
                sent++;
                ex_valid = 1'b0;
            end
            r = $urandom;
            if (!ex_valid && sent < n_trans && r[1:0] != 2'b00) begin
                ex_valid  = 1'b1;
                ex_rd     = (r[7:5] == 3'b000) ? '0 : r[12:8]; // x0 now and then
                ex_word   = r[2];
                ex_result = {$urandom, $urandom};
            end
        end
    endtask

    task automatic load_traffic();
        int          sent;
        int          gen;
        int          fire_cycle;
        logic        fire;
        logic [31:0] r;
        logic [5:0]  combo;
        sent = 0;
        gen = 0;
        while (sent < n_trans) begin
            @(negedge clk);
            fire = mem_valid & mem_ready;
            fire_cycle = cycle_count;
            @(posedge clk);
            #1;
            if (fire) begin
                mem_rd_q.push_back(mem_rd);
                mem_data_q.push_back(aligned_load_value(mem_rdata, mem_offset,
                                                        mem_size, mem_unsigned));
                mem_cycle_q.push_back(fire_cycle);
                sent++;
                mem_valid = 1'b0;
            end
            r = $urandom;
            if (!mem_valid && sent < n_trans && r[1:0] != 2'b00) begin
                combo = (gen < 64) ? gen[5:0] : r[21:16]; // sweep all 64 first
                gen++;
                mem_valid    = 1'b1;
                mem_rd       = (r[7:5] == 3'b000) ? '0 : r[12:8];
                mem_size     = mem_size_e'(combo[5:4]);
                mem_unsigned = combo[3];
                mem_offset   = combo[2:0];
                mem_rdata    = {$urandom, $urandom};
            end
        end
    endtask

    // loads always win, so each one commits two cycles after its transfer
    // and the execute head takes every other commit
    task automatic match_commit();
        logic [addr_w-1:0] exp_rd;
        logic [data_w-1:0] exp_data;
        int                ld_cycle;
        exp_rd   = '0;
        exp_data = '0;
        if (mem_rd_q.size() > 0 && cycle_count - mem_cycle_q[0] >= 2) begin
            exp_rd   = mem_rd_q.pop_front();
            exp_data = mem_data_q.pop_front();
            ld_cycle = mem_cycle_q.pop_front();
            compare_value("commit_rd", 64'(commit_rd), 64'(exp_rd));
            compare_value("commit_data", commit_data, exp_data);
            compare_value("load commit latency", 64'(cycle_count - ld_cycle), 64'd2);
        end else if (ex_rd_q.size() > 0) begin
            exp_rd   = ex_rd_q.pop_front();
            exp_data = ex_data_q.pop_front();
            compare_value("commit_rd", 64'(commit_rd), 64'(exp_rd));
            compare_value("commit_data", commit_data, exp_data);
        end else begin
            $display("commit to register %0d arrived with no result due",
                     commit_rd);
            stop_with_failure();
        end
        if (exp_rd != '0) begin
            model_regs[exp_rd] = exp_data;
        end
        commit_count++;
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (rst_n) begin
                if (commit_valid) begin
                    match_commit();
                end
                if (rd_addr == '0) begin
                    compare_value("rd_data", rd_data, 64'h0); // x0 stays zero
                end
            end
        end
    end

    initial begin
        #(timeout_cycles * 10);
        $display("timeout: traffic did not drain within %0d cycles", timeout_cycles);
        stop_with_failure();
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        ex_valid     = 1'b0;
        ex_rd        = '0;
        ex_result    = '0;
        ex_word      = 1'b0;
        mem_valid    = 1'b0;
        mem_rd       = '0;
        mem_rdata    = '0;
        mem_offset   = '0;
        mem_size     = mem_byte;
        mem_unsigned = 1'b0;
        rd_addr      = '0;
        commit_count = 0;
        for (int i = 0; i < reg_count; i++) begin
            model_regs[i] = '0;
        end
        void'($urandom(32'h34a5ce45));
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        compare_value("ex_ready", 64'(ex_ready), 64'h1);
        compare_value("mem_ready", 64'(mem_ready), 64'h1);
        compare_value("commit_valid", 64'(commit_valid), 64'h0);

        fork
            exec_traffic();
            load_traffic();
        join
        while (ex_rd_q.size() != 0 || mem_rd_q.size() != 0) begin
            @(negedge clk);
        end

        // whole register file against the model
        for (int a = 0; a < reg_count; a++) begin
            @(posedge clk);
            #1;
            rd_addr = a[addr_w-1:0];
            @(negedge clk);
            compare_value("rd_data", rd_data, model_regs[a]);
        end

        if (commit_count == 2 * n_trans) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("saw %0d commits for %0d transfers", commit_count, 2 * n_trans);
            stop_with_failure();
        end
    end

endmodule : tb_wb_subsystem

`default_nettype wire

// ==== verification/wb_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_assert #(
    parameter int reg_count = 32,
    localparam int addr_w = $clog2(reg_count)
) (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      ld_valid,
    input logic                      ld_ready,
    input logic [addr_w-1:0]         ld_rd,
    input logic [wb_pkg::data_w-1:0] ld_data,
    input logic                      fmt_valid,
    input logic                      fmt_ready,
    input logic [addr_w-1:0]         fmt_rd,
    input logic [wb_pkg::data_w-1:0] fmt_data,
    input logic                      wr_en,
    input logic [addr_w-1:0]         wr_addr,
    input logic                      commit_valid
);
    logic grant;

    assign grant = (ld_valid & ld_ready) | (fmt_valid & fmt_ready);

    one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(ld_valid && fmt_valid && ld_ready && fmt_ready))
        else $error("both paths readied while both valid");

    no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> wr_addr != '0)
        else $error("register file write aimed at x0");

    ld_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ld_valid && !ld_ready |=> ld_valid && $stable(ld_rd) && $stable(ld_data))
        else $error("load item changed while waiting");

    fmt_hold: assert property (@(posedge clk) disable iff (!rst_n)
        fmt_valid && !fmt_ready |=> fmt_valid && $stable(fmt_rd) && $stable(fmt_data))
        else $error("execute item changed while waiting");

    commit_after_grant: assert property (@(posedge clk) disable iff (!rst_n)
        grant |=> commit_valid)
        else $error("grant without commit one cycle later");

    // and no commit without a grant before it
    commit_needs_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !grant |=> !commit_valid)
        else $error("commit without a grant");

endmodule : wb_assert

bind wb_arbiter wb_assert #(.reg_count(reg_count)) i_wb_assert (
    .clk          (clk),
    .rst_n        (rst_n),
    .ld_valid     (ld_valid),
    .ld_ready     (ld_ready),
    .ld_rd        (ld_rd),
    .ld_data      (ld_data),
    .fmt_valid    (fmt_valid),
    .fmt_ready    (fmt_ready),
    .fmt_rd       (fmt_rd),
    .fmt_data     (fmt_data),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .commit_valid (commit_valid)
);

`default_nettype wire

// ==== design/wb_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_subsystem #(
    parameter int reg_count = 32,
    localparam int addr_w = $clog2(reg_count)
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          ex_valid,
    output logic                          ex_ready,
    input  logic [addr_w-1:0]             ex_rd,
    input  logic [wb_pkg::data_w-1:0]     ex_result,
    input  logic                          ex_word,
    input  logic                          mem_valid,
    output logic                          mem_ready,
    input  logic [addr_w-1:0]             mem_rd,
    input  logic [wb_pkg::data_w-1:0]     mem_rdata,
    input  logic [wb_pkg::offset_w-1:0]   mem_offset,
    input  wb_pkg::mem_size_e             mem_size,
    input  logic                          mem_unsigned,
    input  logic [addr_w-1:0]             rd_addr,
    output logic [wb_pkg::data_w-1:0]     rd_data,
    output logic                          commit_valid,
    output logic [addr_w-1:0]             commit_rd,
    output logic [wb_pkg::data_w-1:0]     commit_data
);
    import wb_pkg::*;

    logic              fmt_valid;
    logic              fmt_ready;
    logic [addr_w-1:0] fmt_rd;
    logic [data_w-1:0] fmt_data;
    logic              ld_valid;
    logic              ld_ready;
    logic [addr_w-1:0] ld_rd;
    logic [data_w-1:0] ld_data;
    logic              wr_en;
    logic [addr_w-1:0] wr_addr;
    logic [data_w-1:0] wr_data;

    exec_result_fmt #(.reg_count(reg_count)) i_exec_fmt (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_valid  (ex_valid),
        .ex_ready  (ex_ready),
        .ex_rd     (ex_rd),
        .ex_result (ex_result),
        .ex_word   (ex_word),
        .fmt_valid (fmt_valid),
        .fmt_ready (fmt_ready),
        .fmt_rd    (fmt_rd),
        .fmt_data  (fmt_data)
    );

    load_align #(.reg_count(reg_count)) i_load_align (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_valid    (mem_valid),
        .mem_ready    (mem_ready),
        .mem_rd       (mem_rd),
        .mem_rdata    (mem_rdata),
        .mem_offset   (mem_offset),
        .mem_size     (mem_size),
        .mem_unsigned (mem_unsigned),
        .ld_valid     (ld_valid),
        .ld_ready     (ld_ready),
        .ld_rd        (ld_rd),
        .ld_data      (ld_data)
    );

    wb_arbiter #(.reg_count(reg_count)) i_wb_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .ld_valid     (ld_valid),
        .ld_ready     (ld_ready),
        .ld_rd        (ld_rd),
        .ld_data      (ld_data),
        .fmt_valid    (fmt_valid),
        .fmt_ready    (fmt_ready),
        .fmt_rd       (fmt_rd),
        .fmt_data     (fmt_data),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

    gpr_file #(.reg_count(reg_count)) i_gpr_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule : wb_subsystem

`default_nettype wire

// ==== design/gpr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpr_file #(
    parameter int reg_count = 32,
    localparam int addr_w = $clog2(reg_count)
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wr_en,
    input  logic [addr_w-1:0]         wr_addr,
    input  logic [wb_pkg::data_w-1:0] wr_data,
    input  logic [addr_w-1:0]         rd_addr,
    output logic [wb_pkg::data_w-1:0] rd_data
);
    import wb_pkg::*;

    // storage starts at x1, x0 has no flops
    logic [data_w-1:0] regs [1:reg_count-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            for (int i = 1; i < reg_count; i++) begin
                if (wr_addr == addr_w'(i)) begin
                    regs[i] <= wr_data;
                end
            end
        end
    end

    // read mux, an address of zero falls through to the default
    always_comb begin
        rd_data = '0;
        for (int i = 1; i < reg_count; i++) begin
            if (rd_addr == addr_w'(i)) begin
                rd_data = regs[i];
            end
        end
    end

endmodule : gpr_file

`default_nettype wire

// ==== design/wb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter #(
    parameter int reg_count = 32,
    localparam int addr_w = $clog2(reg_count)
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ld_valid,
    output logic                      ld_ready,
    input  logic [addr_w-1:0]         ld_rd,
    input  logic [wb_pkg::data_w-1:0] ld_data,
    input  logic                      fmt_valid,
    output logic                      fmt_ready,
    input  logic [addr_w-1:0]         fmt_rd,
    input  logic [wb_pkg::data_w-1:0] fmt_data,
    output logic                      wr_en,
    output logic [addr_w-1:0]         wr_addr,
    output logic [wb_pkg::data_w-1:0] wr_data,
    output logic                      commit_valid,
    output logic [addr_w-1:0]         commit_rd,
    output logic [wb_pkg::data_w-1:0] commit_data
);
    import wb_pkg::*;

    logic              grant_ld;
    logic              grant_fmt;
    logic              granted;
    logic [addr_w-1:0] sel_rd;
    logic [data_w-1:0] sel_data;

    // loads win, the execute path waits behind them
    assign grant_ld  = ld_valid;
    assign grant_fmt = fmt_valid & ~ld_valid;
    assign granted   = grant_ld | grant_fmt;

    assign ld_ready  = grant_ld;
    assign fmt_ready = grant_fmt;

    assign sel_rd   = grant_ld ? ld_rd   : fmt_rd;
    assign sel_data = grant_ld ? ld_data : fmt_data;

    // x0 target retires but never reaches the register file
    assign wr_en   = granted & (sel_rd != '0);
    assign wr_addr = sel_rd;
    assign wr_data = sel_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= granted; // one cycle after the write edge
        end
    end

    always_ff @(posedge clk) begin
        if (granted) begin
            commit_rd   <= sel_rd;
            commit_data <= sel_data;
        end
    end

endmodule : wb_arbiter

`default_nettype wire

// ==== design/exec_result_fmt.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_result_fmt #(
    parameter int reg_count = 32,
    localparam int addr_w = $clog2(reg_count)
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ex_valid,
    output logic                      ex_ready,
    input  logic [addr_w-1:0]         ex_rd,
    input  logic [wb_pkg::data_w-1:0] ex_result,
    input  logic                      ex_word,
    output logic                      fmt_valid,
    input  logic                      fmt_ready,
    output logic [addr_w-1:0]         fmt_rd,
    output logic [wb_pkg::data_w-1:0] fmt_data
);
    import wb_pkg::*;

    logic [data_w-1:0] formatted;
    logic              accept;

    // addw, subw, sllw and friends keep only the low word
    assign formatted = ex_word ?
        {{(data_w - word_w){ex_result[word_w-1]}}, ex_result[word_w-1:0]} :
        ex_result;

    assign ex_ready = ~fmt_valid | fmt_ready; // refill in the drain cycle
    assign accept   = ex_valid & ex_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fmt_valid <= 1'b0;
        end else if (ex_ready) begin
            fmt_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            fmt_rd   <= ex_rd;
            fmt_data <= formatted; // held under back-pressure
        end
    end

endmodule : exec_result_fmt

`default_nettype wire

// ==== design/load_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_align #(
    parameter int reg_count = 32,
    localparam int addr_w = $clog2(reg_count)
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          mem_valid,
    output logic                          mem_ready,
    input  logic [addr_w-1:0]             mem_rd,
    input  logic [wb_pkg::data_w-1:0]     mem_rdata,
    input  logic [wb_pkg::offset_w-1:0]   mem_offset,
    input  wb_pkg::mem_size_e             mem_size,
    input  logic                          mem_unsigned,
    output logic                          ld_valid,
    input  logic                          ld_ready,
    output logic [addr_w-1:0]             ld_rd,
    output logic [wb_pkg::data_w-1:0]     ld_data
);
    import wb_pkg::*;

    logic [data_w-1:0] shifted;
    logic [data_w-1:0] aligned;
    logic              sext;    // high when sign extension applies
    logic              accept;

    // byte offset turned into a bit shift, zeros fill from the top
    assign shifted = mem_rdata >> {mem_offset, 3'b000};
    assign sext    = ~mem_unsigned;

    always_comb begin
        case (mem_size)
            mem_byte: begin
                aligned = {{(data_w - 8){sext & shifted[7]}}, shifted[7:0]};
            end
            mem_half: begin
                aligned = {{(data_w - 16){sext & shifted[15]}}, shifted[15:0]};
            end
            mem_word: begin
                aligned = {{(data_w - word_w){sext & shifted[word_w-1]}},
                           shifted[word_w-1:0]};
            end
            default: begin
                aligned = shifted; // double, flag ignored
            end
        endcase
    end

    // stage is free when empty or drained this cycle
    assign mem_ready = ~ld_valid | ld_ready;
    assign accept    = mem_valid & mem_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld_valid <= 1'b0;
        end else if (mem_ready) begin
            ld_valid <= mem_valid;
        end
    end

    // payload only moves on a transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            ld_rd   <= mem_rd;
            ld_data <= aligned;
        end
    end

endmodule : load_align

`default_nettype wire

// ==== design/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

    // integer register and result width
    localparam int data_w = 64;

    // low half used by the 32-bit word ops
    localparam int word_w = 32;

    // byte offset of a load inside one doubleword
    localparam int offset_w = 3;

    // load access size, matches funct3[1:0] of the load opcodes
    typedef enum logic [1:0] {
        mem_byte   = 2'b00,
        mem_half   = 2'b01,
        mem_word   = 2'b10,
        mem_double = 2'b11
    } mem_size_e;

endpackage : wb_pkg

`default_nettype wire
